// ==== hw/core_pkg.sv ====
// shared widths, opcodes, funct3 codes, bus and trap codes, ALU operation enum
package core_pkg;

  localparam int XLEN       = 64;
  localparam int ILEN       = 32;
  localparam int REG_ADDR_W = 5;

  localparam logic [XLEN-1:0] RESET_PC = 64'h0;

  // major opcodes
  localparam logic [6:0] OPC_OP_IMM = 7'h13;
  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_AUIPC  = 7'h17;
  localparam logic [6:0] OPC_JAL    = 7'h6f;
  localparam logic [6:0] OPC_JALR   = 7'h67;
  localparam logic [6:0] OPC_BRANCH = 7'h63;
  // custom halt, trap code taken from x10
  localparam logic [6:0] OPC_HALT   = 7'h6b;

  // funct3 for OP / OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 for branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // fetch bus codes
  localparam logic [1:0] IF_SIZE_WORD = 2'd2;
  localparam logic [1:0] RESP_OKAY    = 2'd0;

  localparam logic [7:0] TRAP_BUS_ERR = 8'hff;
  localparam logic [7:0] TRAP_ILLEGAL = 8'hfe;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_t;

endpackage

// ==== hw/core_intf.sv ====
// fetch_bus and commit_bus interfaces with source and sink modports
`timescale 1ns/10ps

interface fetch_bus import core_pkg::*; ();
  // one-cycle pulse marking the execute cycle
  logic            inst_valid;
  logic [ILEN-1:0] inst;
  logic [XLEN-1:0] pc;
  logic            bus_err;

  modport source (output inst_valid, output inst, output pc, output bus_err);
  modport sink   (input inst_valid, input inst, input pc, input bus_err);
endinterface

interface commit_bus import core_pkg::*; ();
  logic                  valid;
  logic                  rd_wen;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       rd_wdata;
  // decoder flag, wired in at the top level
  logic                  illegal;

  modport source (
    output valid,
    output rd_wen,
    output rd,
    output rd_wdata,
    input  illegal
  );
  modport sink (
    input valid,
    input rd_wen,
    input rd,
    input rd_wdata,
    input illegal
  );
endinterface

// ==== hw/fetch_unit.sv ====
// fetch sequencer: program counter, instruction bus requests, instruction capture
`timescale 1ns/10ps

module fetch_unit import core_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  input  logic [XLEN-1:0]  next_pc_i,
  input  logic             halted_i,
  output logic             if_valid_o,
  output logic [XLEN-1:0]  if_addr_o,
  output logic [1:0]       if_size_o,
  input  logic             if_ready_i,
  input  logic [XLEN-1:0]  if_data_read_i,
  input  logic [1:0]       if_resp_i,
  fetch_bus.source         fb
);

  // S_WAIT is the idle state after reset and the parking state after a trap
  typedef enum logic [1:0] {
    S_WAIT,
    S_REQ,
    S_EXEC
  } state_t;

  state_t          state_q;
  logic [XLEN-1:0] pc_q;
  logic [ILEN-1:0] inst_q;
  logic            err_q;
  logic            xfer;

  assign if_valid_o = (state_q == S_REQ) && !halted_i;
  assign if_addr_o  = pc_q;
  assign if_size_o  = IF_SIZE_WORD;

  assign xfer = if_valid_o && if_ready_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= S_WAIT;
      pc_q    <= RESET_PC;
    end else begin
      case (state_q)
        S_WAIT: begin
          if (!halted_i) begin
            state_q <= S_REQ;
          end
        end
        S_REQ: begin
          // halted shows up here in the commit cycle of a trap
          if (halted_i) begin
            state_q <= S_WAIT;
          end else if (if_ready_i) begin
            state_q <= S_EXEC;
          end
        end
        S_EXEC: begin
          state_q <= S_REQ;
          pc_q    <= next_pc_i;
        end
        default: begin
          state_q <= S_WAIT;
        end
      endcase
    end
  end

  // word select by address bit 2
  always_ff @(posedge clock) begin
    if (xfer) begin
      inst_q <= pc_q[2] ? if_data_read_i[2*ILEN-1:ILEN] : if_data_read_i[ILEN-1:0];
      err_q  <= (if_resp_i != RESP_OKAY);
    end
  end

  assign fb.inst_valid = (state_q == S_EXEC);
  assign fb.inst       = inst_q;
  assign fb.pc         = pc_q;
  assign fb.bus_err    = err_q;

endmodule

// ==== hw/decoder.sv ====
// instruction decoder: field split, immediates, operand select, ALU op, illegal check
`timescale 1ns/10ps

module decoder import core_pkg::*; (
  fetch_bus.sink                 fb,
  output logic [REG_ADDR_W-1:0]  rs1_o,
  output logic [REG_ADDR_W-1:0]  rs2_o,
  input  logic [XLEN-1:0]        rs1_data_i,
  input  logic [XLEN-1:0]        rs2_data_i,
  output logic [XLEN-1:0]        op_a_o,
  output logic [XLEN-1:0]        op_b_o,
  output alu_op_t                alu_op_o,
  output logic [XLEN-1:0]        imm_o,
  output logic [REG_ADDR_W-1:0]  rd_o,
  output logic                   rd_wen_o,
  output logic                   is_branch_o,
  output logic                   is_jal_o,
  output logic                   is_jalr_o,
  output logic                   is_halt_o,
  output logic [2:0]             funct3_o,
  output logic                   illegal_o
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic            alt;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic            writes_rd;

  assign opcode = fb.inst[6:0];
  assign funct3 = fb.inst[14:12];
  // bit 30 picks sub and sra
  assign alt    = fb.inst[30];

  assign rd_o     = fb.inst[11:7];
  assign rs1_o    = fb.inst[19:15];
  assign rs2_o    = fb.inst[24:20];
  assign funct3_o = funct3;

  assign imm_i = {{(XLEN-12){fb.inst[31]}}, fb.inst[31:20]};
  assign imm_b = {{(XLEN-13){fb.inst[31]}}, fb.inst[31], fb.inst[7],
                  fb.inst[30:25], fb.inst[11:8], 1'b0};
  assign imm_u = {{(XLEN-32){fb.inst[31]}}, fb.inst[31:12], 12'b0};
  assign imm_j = {{(XLEN-21){fb.inst[31]}}, fb.inst[31], fb.inst[19:12],
                  fb.inst[20], fb.inst[30:21], 1'b0};

  always_comb begin
    imm_o       = imm_i;
    op_a_o      = rs1_data_i;
    op_b_o      = rs2_data_i;
    writes_rd   = 1'b0;
    is_branch_o = 1'b0;
    is_jal_o    = 1'b0;
    is_jalr_o   = 1'b0;
    is_halt_o   = 1'b0;
    illegal_o   = 1'b0;
    case (opcode)
      OPC_OP_IMM: begin
        op_b_o    = imm_i;
        writes_rd = 1'b1;
      end
      OPC_OP: begin
        writes_rd = 1'b1;
      end
      OPC_LUI: begin
        imm_o     = imm_u;
        op_b_o    = imm_u;
        writes_rd = 1'b1;
      end
      OPC_AUIPC: begin
        imm_o     = imm_u;
        op_a_o    = fb.pc;
        op_b_o    = imm_u;
        writes_rd = 1'b1;
      end
      OPC_JAL: begin
        imm_o     = imm_j;
        writes_rd = 1'b1;
        is_jal_o  = 1'b1;
      end
      OPC_JALR: begin
        op_b_o    = imm_i;
        writes_rd = 1'b1;
        is_jalr_o = 1'b1;
      end
      OPC_BRANCH: begin
        imm_o       = imm_b;
        is_branch_o = 1'b1;
      end
      OPC_HALT: is_halt_o = 1'b1;
      default:  illegal_o = 1'b1;
    endcase
  end

  // x0 destination never writes
  assign rd_wen_o = writes_rd && (rd_o != '0);

  always_comb begin
    alu_op_o = ALU_ADD;
    if (opcode == OPC_LUI) begin
      alu_op_o = ALU_PASS_B;
    end else if (opcode == OPC_OP_IMM || opcode == OPC_OP) begin
      case (funct3)
        F3_ADD_SUB: alu_op_o = (opcode == OPC_OP && alt) ? ALU_SUB : ALU_ADD;
        F3_SLL:     alu_op_o = ALU_SLL;
        F3_SLT:     alu_op_o = ALU_SLT;
        F3_SLTU:    alu_op_o = ALU_SLTU;
        F3_XOR:     alu_op_o = ALU_XOR;
        F3_SRL_SRA: alu_op_o = alt ? ALU_SRA : ALU_SRL;
        F3_OR:      alu_op_o = ALU_OR;
        F3_AND:     alu_op_o = ALU_AND;
        default:    alu_op_o = ALU_ADD;
      endcase
    end
  end

endmodule

// ==== hw/regfile.sv ====
// 32 x 64 integer register file, two read ports, one write port, x0 reads zero
`timescale 1ns/10ps

module regfile import core_pkg::*; (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [REG_ADDR_W-1:0]  rs1_i,
  input  logic [REG_ADDR_W-1:0]  rs2_i,
  output logic [XLEN-1:0]        rs1_data_o,
  output logic [XLEN-1:0]        rs2_data_o,
  input  logic [REG_ADDR_W-1:0]  rd_i,
  input  logic                   rd_wen_i,
  input  logic [XLEN-1:0]        rd_wdata_i,
  output logic [XLEN-1:0]        x10_o
);

  logic [XLEN-1:0] regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_wen_i && (rd_i != '0)) begin
      regs[rd_i] <= rd_wdata_i;
    end
  end

  // x0 is never written, so it stays at its reset value
  assign rs1_data_o = regs[rs1_i];
  assign rs2_data_o = regs[rs2_i];
  // halt trap code source
  assign x10_o      = regs[10];

endmodule

// ==== hw/exec_unit.sv ====
// execute stage: ALU, branch compare, link value and next PC
`timescale 1ns/10ps

module exec_unit import core_pkg::*; (
  fetch_bus.sink                 fb,
  input  logic [XLEN-1:0]        op_a_i,
  input  logic [XLEN-1:0]        op_b_i,
  input  alu_op_t                alu_op_i,
  input  logic [XLEN-1:0]        imm_i,
  input  logic [REG_ADDR_W-1:0]  rd_i,
  input  logic                   rd_wen_i,
  input  logic                   is_branch_i,
  input  logic                   is_jal_i,
  input  logic                   is_jalr_i,
  input  logic [2:0]             funct3_i,
  input  logic [XLEN-1:0]        rs1_data_i,
  input  logic [XLEN-1:0]        rs2_data_i,
  output logic [XLEN-1:0]        next_pc_o,
  commit_bus.source              cb
);

  logic [5:0]      shamt;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] link;
  logic [XLEN-1:0] jalr_sum;
  logic            taken;

  // RV64 shifts use 6 bits
  assign shamt = op_b_i[5:0];

  always_comb begin
    case (alu_op_i)
      ALU_ADD:    alu_res = op_a_i + op_b_i;
      ALU_SUB:    alu_res = op_a_i - op_b_i;
      ALU_SLL:    alu_res = op_a_i << shamt;
      ALU_SLT:    alu_res = XLEN'($signed(op_a_i) < $signed(op_b_i));
      ALU_SLTU:   alu_res = XLEN'(op_a_i < op_b_i);
      ALU_XOR:    alu_res = op_a_i ^ op_b_i;
      ALU_SRL:    alu_res = op_a_i >> shamt;
      ALU_SRA:    alu_res = $signed(op_a_i) >>> shamt;
      ALU_OR:     alu_res = op_a_i | op_b_i;
      ALU_AND:    alu_res = op_a_i & op_b_i;
      ALU_PASS_B: alu_res = op_b_i;
      default:    alu_res = op_a_i + op_b_i;
    endcase
  end

  always_comb begin
    case (funct3_i)
      F3_BEQ:  taken = (rs1_data_i == rs2_data_i);
      F3_BNE:  taken = (rs1_data_i != rs2_data_i);
      F3_BLT:  taken = ($signed(rs1_data_i) < $signed(rs2_data_i));
      F3_BGE:  taken = ($signed(rs1_data_i) >= $signed(rs2_data_i));
      F3_BLTU: taken = (rs1_data_i < rs2_data_i);
      F3_BGEU: taken = (rs1_data_i >= rs2_data_i);
      default: taken = 1'b0;
    endcase
  end

  assign link     = fb.pc + XLEN'(4);
  assign jalr_sum = rs1_data_i + imm_i;

  always_comb begin
    if (is_jalr_i) begin
      next_pc_o = {jalr_sum[XLEN-1:1], 1'b0};
    end else if (is_jal_i || (is_branch_i && taken)) begin
      next_pc_o = fb.pc + imm_i;
    end else begin
      next_pc_o = link;
    end
  end

  assign cb.valid    = fb.inst_valid;
  // no write for a failed fetch or an unknown opcode
  assign cb.rd_wen   = fb.inst_valid && rd_wen_i && !fb.bus_err && !cb.illegal;
  assign cb.rd       = rd_i;
  assign cb.rd_wdata = (is_jal_i || is_jalr_i) ? link : alu_res;

endmodule

// ==== hw/commit_unit.sv ====
// commit record register, trap latch with code priority, retired instruction counter
`timescale 1ns/10ps

module commit_unit import core_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  fetch_bus.sink           fb,
  commit_bus.sink          cb,
  input  logic             is_halt_i,
  input  logic [XLEN-1:0]  x10_i,
  output logic             halted_o,
  output logic             commit_valid_o,
  output logic [XLEN-1:0]  commit_pc_o,
  output logic [ILEN-1:0]  commit_inst_o,
  output logic             commit_wen_o,
  output logic [7:0]       commit_wdest_o,
  output logic [XLEN-1:0]  commit_wdata_o,
  output logic             trap_valid_o,
  output logic [7:0]       trap_code_o,
  output logic [63:0]      instr_count_o
);

  logic       trap_now;
  logic [7:0] code_now;

  assign trap_now = fb.bus_err || cb.illegal || is_halt_i;

  // bus error beats illegal, illegal beats halt
  assign code_now = fb.bus_err  ? TRAP_BUS_ERR :
                    cb.illegal  ? TRAP_ILLEGAL : x10_i[7:0];

  always_ff @(posedge clock) begin
    if (reset) begin
      commit_valid_o <= 1'b0;
      trap_valid_o   <= 1'b0;
      trap_code_o    <= '0;
      instr_count_o  <= '0;
    end else begin
      commit_valid_o <= cb.valid;
      if (cb.valid) begin
        instr_count_o <= instr_count_o + 64'd1;
        if (trap_now) begin
          trap_valid_o <= 1'b1;
          trap_code_o  <= code_now;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (cb.valid) begin
      commit_pc_o    <= fb.pc;
      commit_inst_o  <= fb.inst;
      commit_wen_o   <= cb.rd_wen;
      commit_wdest_o <= 8'(cb.rd);
      commit_wdata_o <= cb.rd_wdata;
    end
  end

  // sticky until reset
  assign halted_o = trap_valid_o;

endmodule

// ==== hw/core_top.sv ====
// core top level: fetch, decode, register file, execute and commit units
`timescale 1ns/10ps

module core_top import core_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  output logic             if_valid_o,
  input  logic             if_ready_i,
  input  logic [XLEN-1:0]  if_data_read_i,
  output logic [XLEN-1:0]  if_addr_o,
  output logic [1:0]       if_size_o,
  input  logic [1:0]       if_resp_i,
  output logic             commit_valid_o,
  output logic [XLEN-1:0]  commit_pc_o,
  output logic [ILEN-1:0]  commit_inst_o,
  output logic             commit_wen_o,
  output logic [7:0]       commit_wdest_o,
  output logic [XLEN-1:0]  commit_wdata_o,
  output logic             trap_valid_o,
  output logic [7:0]       trap_code_o,
  output logic [63:0]      instr_count_o
);

  fetch_bus  fb ();
  commit_bus cb ();

  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  logic [XLEN-1:0]       x10;
  logic [XLEN-1:0]       op_a;
  logic [XLEN-1:0]       op_b;
  logic [XLEN-1:0]       imm;
  logic [XLEN-1:0]       next_pc;
  alu_op_t               alu_op;
  logic [2:0]            funct3;
  logic                  rd_wen;
  logic                  is_branch;
  logic                  is_jal;
  logic                  is_jalr;
  logic                  is_halt;
  logic                  illegal;
  logic                  halted;

  // decoder flag joins the commit bus here
  assign cb.illegal = illegal;

  fetch_unit u_fetch (
    .clock          (clock),
    .reset          (reset),
    .next_pc_i      (next_pc),
    .halted_i       (halted),
    .if_valid_o     (if_valid_o),
    .if_addr_o      (if_addr_o),
    .if_size_o      (if_size_o),
    .if_ready_i     (if_ready_i),
    .if_data_read_i (if_data_read_i),
    .if_resp_i      (if_resp_i),
    .fb             (fb.source)
  );

  decoder u_decoder (
    .fb          (fb.sink),
    .rs1_o       (rs1),
    .rs2_o       (rs2),
    .rs1_data_i  (rs1_data),
    .rs2_data_i  (rs2_data),
    .op_a_o      (op_a),
    .op_b_o      (op_b),
    .alu_op_o    (alu_op),
    .imm_o       (imm),
    .rd_o        (rd),
    .rd_wen_o    (rd_wen),
    .is_branch_o (is_branch),
    .is_jal_o    (is_jal),
    .is_jalr_o   (is_jalr),
    .is_halt_o   (is_halt),
    .funct3_o    (funct3),
    .illegal_o   (illegal)
  );

  // write port comes off the commit bus
  regfile u_regfile (
    .clock      (clock),
    .reset      (reset),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .rd_i       (cb.rd),
    .rd_wen_i   (cb.rd_wen),
    .rd_wdata_i (cb.rd_wdata),
    .x10_o      (x10)
  );

  exec_unit u_exec (
    .fb          (fb.sink),
    .op_a_i      (op_a),
    .op_b_i      (op_b),
    .alu_op_i    (alu_op),
    .imm_i       (imm),
    .rd_i        (rd),
    .rd_wen_i    (rd_wen),
    .is_branch_i (is_branch),
    .is_jal_i    (is_jal),
    .is_jalr_i   (is_jalr),
    .funct3_i    (funct3),
    .rs1_data_i  (rs1_data),
    .rs2_data_i  (rs2_data),
    .next_pc_o   (next_pc),
    .cb          (cb.source)
  );

  commit_unit u_commit (
    .clock          (clock),
    .reset          (reset),
    .fb             (fb.sink),
    .cb             (cb.sink),
    .is_halt_i      (is_halt),
    .x10_i          (x10),
    .halted_o       (halted),
    .commit_valid_o (commit_valid_o),
    .commit_pc_o    (commit_pc_o),
    .commit_inst_o  (commit_inst_o),
    .commit_wen_o   (commit_wen_o),
    .commit_wdest_o (commit_wdest_o),
    .commit_wdata_o (commit_wdata_o),
    .trap_valid_o   (trap_valid_o),
    .trap_code_o    (trap_code_o),
    .instr_count_o  (instr_count_o)
  );

endmodule

// ==== test/tb_core.sv ====
// testbench for core_top: clock, reset, instruction memory model, watchdog, directed tests
`timescale 1ns/10ps

module tb_core import core_pkg::*;;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 8;
  localparam int QUIET_CYCLES = 20;
  localparam int STALL_CYCLES = 10;
  localparam int NUM_TESTS    = 6;
  // instructions retired over all six programs
  localparam int TOTAL_INSTR  = 74;
  localparam int WATCHDOG_CYCLES = TOTAL_INSTR * 12 + NUM_TESTS * (RESET_CYCLES + QUIET_CYCLES);

  logic        clock;
  logic        reset;
  logic        if_valid_o;
  logic        if_ready_i;
  logic [63:0] if_data_read_i;
  logic [63:0] if_addr_o;
  logic [1:0]  if_size_o;
  logic [1:0]  if_resp_i;
  logic        commit_valid_o;
  logic [63:0] commit_pc_o;
  logic [31:0] commit_inst_o;
  logic        commit_wen_o;
  logic [7:0]  commit_wdest_o;
  logic [63:0] commit_wdata_o;
  logic        trap_valid_o;
  logic [7:0]  trap_code_o;
  logic [63:0] instr_count_o;

  // program memory and reference register state
  logic [31:0] imem [256];
  logic [63:0] xr [32];
  logic [63:0] prog_pc;

  logic [63:0] exp_pc [$];
  logic [31:0] exp_inst [$];
  logic        exp_wen [$];
  logic [7:0]  exp_rd [$];
  logic [63:0] exp_val [$];
  logic [63:0] c_pc [$];
  logic [31:0] c_inst [$];
  logic        c_wen [$];
  logic [7:0]  c_wdest [$];
  logic [63:0] c_wdata [$];

  // memory model state
  integer      seed = 27;
  int          wait_left = -1;
  int          fetch_count = 0;
  int          stall_req = -1;
  logic        stall_seen = 1'b0;
  logic [63:0] err_addr = '1;
  logic [63:0] req_addr;
  logic [6:0]  dw;

  string       cur_test = "none";
  int          errors = 0;
  int          n_pass = 0;
  int          n_fail = 0;

  core_top dut0 (.*);

  always #(CLK_PERIOD / 2) clock = ~clock;

  // memory answers after 0 to 3 idle cycles, plus a long stall on request stall_req
  always @(posedge clock) begin
    #10;
    if_ready_i = 1'b0;
    if (if_valid_o) begin
      assert (if_size_o == IF_SIZE_WORD) else begin
        errors++;
        $display("Mismatch: %s: if_size_o expected %0d, actual %0d", cur_test, IF_SIZE_WORD,
                 if_size_o);
      end
      if (wait_left < 0) begin
        req_addr  = if_addr_o;
        wait_left = $unsigned($random(seed)) % 4;
        if (fetch_count == stall_req) begin
          wait_left  = wait_left + STALL_CYCLES;
          stall_seen = 1'b1;
        end
      end else begin
        assert (if_addr_o == req_addr) else begin
          errors++;
          $display("Mismatch: %s: if_addr_o expected %h, actual %h", cur_test, req_addr,
                   if_addr_o);
        end
      end
      if (wait_left == 0) begin
        dw             = if_addr_o[9:3];
        if_ready_i     = 1'b1;
        if_data_read_i = {imem[{dw, 1'b1}], imem[{dw, 1'b0}]};
        if_resp_i      = (if_addr_o == err_addr) ? 2'b10 : RESP_OKAY;
        fetch_count++;
        wait_left      = -1;
      end else begin
        wait_left--;
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("ERROR: timeout in test %s, the core stopped committing instructions", cur_test);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  function automatic logic [63:0] sx(int v);
    return 64'(v);
  endfunction

  function automatic logic [63:0] u_imm(logic [19:0] v);
    return {{32{v[19]}}, v, 12'h000};
  endfunction

  function automatic logic [31:0] itype(logic [6:0] opc, int rd, logic [2:0] f3, int rs1,
                                        int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic logic [31:0] rtype(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3,
                                        int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
  endfunction

  function automatic logic [31:0] utype(logic [6:0] opc, int rd, logic [19:0] imm);
    return {imm, rd[4:0], opc};
  endfunction

  function automatic logic [31:0] btype(logic [2:0] f3, int rs1, int rs2, int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] jtype(int rd, int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
  endfunction

  function automatic logic [31:0] addi(int rd, int rs1, int imm);
    return itype(OPC_OP_IMM, rd, F3_ADD_SUB, rs1, imm);
  endfunction

  function automatic logic [31:0] halt_word();
    return {25'h0, OPC_HALT};
  endfunction

  task automatic next_cycle();
    @(posedge clock);
    #10;
  endtask

  task automatic begin_program(string name);
    cur_test = name;
    errors   = 0;
    exp_pc.delete();
    exp_inst.delete();
    exp_wen.delete();
    exp_rd.delete();
    exp_val.delete();
    // stray fetches hit halt words that carry their own address
    for (int i = 0; i < 256; i++) begin
      imem[i] = {i[24:0], OPC_HALT};
    end
    for (int i = 0; i < 32; i++) begin
      xr[i] = '0;
    end
    prog_pc     = '0;
    err_addr    = '1;
    stall_req   = -1;
    stall_seen  = 1'b0;
    fetch_count = 0;
  endtask

  // place one instruction and record the commit it should produce
  task automatic put(logic [31:0] inst, logic wen, int rd, logic [63:0] val);
    imem[prog_pc[9:2]] = inst;
    exp_pc.push_back(prog_pc);
    exp_inst.push_back(inst);
    exp_wen.push_back(wen && rd != 0);
    exp_rd.push_back(8'(rd));
    exp_val.push_back(val);
    if (wen && rd != 0) begin
      xr[rd] = val;
    end
    prog_pc = prog_pc + 64'd4;
  endtask

  task automatic run_program();
    c_pc.delete();
    c_inst.delete();
    c_wen.delete();
    c_wdest.delete();
    c_wdata.delete();
    reset = 1'b1;
    repeat (RESET_CYCLES) next_cycle();
    reset = 1'b0;
    while (!trap_valid_o) begin
      next_cycle();
      if (commit_valid_o) begin
        c_pc.push_back(commit_pc_o);
        c_inst.push_back(commit_inst_o);
        c_wen.push_back(commit_wen_o);
        c_wdest.push_back(commit_wdest_o);
        c_wdata.push_back(commit_wdata_o);
      end
    end
  endtask

  task automatic check_commits(logic [7:0] exp_code);
    int n;
    n = (c_pc.size() < exp_pc.size()) ? c_pc.size() : exp_pc.size();
    assert (c_pc.size() == exp_pc.size()) else begin
      errors++;
      $display("Mismatch: %s: commit count expected %0d, actual %0d", cur_test,
               exp_pc.size(), c_pc.size());
    end
    for (int i = 0; i < n; i++) begin
      assert (c_pc[i] == exp_pc[i]) else begin
        errors++;
        $display("Mismatch: %s: commit %0d pc expected %h, actual %h", cur_test, i,
                 exp_pc[i], c_pc[i]);
      end
      assert (c_inst[i] == exp_inst[i]) else begin
        errors++;
        $display("Mismatch: %s: commit %0d inst expected %h, actual %h", cur_test, i,
                 exp_inst[i], c_inst[i]);
      end
      assert (c_wen[i] == exp_wen[i]) else begin
        errors++;
        $display("Mismatch: %s: commit %0d wen expected %b, actual %b", cur_test, i,
                 exp_wen[i], c_wen[i]);
      end
      if (exp_wen[i]) begin
        assert (c_wdest[i] == exp_rd[i]) else begin
          errors++;
          $display("Mismatch: %s: commit %0d wdest expected %0d, actual %0d", cur_test, i,
                   exp_rd[i], c_wdest[i]);
        end
        assert (c_wdata[i] == exp_val[i]) else begin
          errors++;
          $display("Mismatch: %s: commit %0d wdata expected %h, actual %h", cur_test, i,
                   exp_val[i], c_wdata[i]);
        end
      end
    end
    assert (trap_code_o == exp_code) else begin
      errors++;
      $display("Mismatch: %s: trap code expected %h, actual %h", cur_test, exp_code,
               trap_code_o);
    end
    assert (instr_count_o == 64'(c_pc.size())) else begin
      errors++;
      $display("Mismatch: %s: instr count expected %0d, actual %0d", cur_test, c_pc.size(),
               instr_count_o);
    end
  endtask

  // after a trap the core must stay silent on the fetch bus
  task automatic check_quiet();
    int fc;
    fc = fetch_count;
    repeat (QUIET_CYCLES) begin
      next_cycle();
      assert (!if_valid_o && trap_valid_o) else begin
        errors++;
        $display("ERROR: %s: core left the trapped state and requested a fetch", cur_test);
      end
    end
    assert (fetch_count == fc) else begin
      errors++;
      $display("Mismatch: %s: fetch count expected %0d, actual %0d", cur_test, fc, fetch_count);
    end
  endtask

  task automatic finish_test();
    if (errors == 0) begin
      $display("test %s: passed", cur_test);
      n_pass++;
    end else begin
      $display("test %s: failed with %0d errors", cur_test, errors);
      n_fail++;
    end
  endtask

  task automatic build_alu_program();
    put(addi(1, 0, 5), 1, 1, sx(5));
    put(addi(2, 0, -3), 1, 2, sx(-3));
    put(utype(OPC_LUI, 3, 20'h12345), 1, 3, u_imm(20'h12345));
    put(utype(OPC_LUI, 4, 20'h80000), 1, 4, u_imm(20'h80000));
    put(utype(OPC_AUIPC, 5, 20'h00001), 1, 5, prog_pc + u_imm(20'h00001));
    put(rtype(7'h00, 2, 1, F3_ADD_SUB, 6), 1, 6, xr[1] + xr[2]);
    put(rtype(7'h20, 2, 1, F3_ADD_SUB, 7), 1, 7, xr[1] - xr[2]);
    put(rtype(7'h00, 1, 2, F3_SLT, 8), 1, 8, {63'b0, $signed(xr[2]) < $signed(xr[1])});
    put(rtype(7'h00, 1, 2, F3_SLTU, 9), 1, 9, {63'b0, xr[2] < xr[1]});
    put(rtype(7'h00, 2, 1, F3_XOR, 11), 1, 11, xr[1] ^ xr[2]);
    put(rtype(7'h00, 1, 1, F3_SLL, 12), 1, 12, xr[1] << xr[1][5:0]);
    put(rtype(7'h00, 1, 4, F3_SRL_SRA, 13), 1, 13, xr[4] >> xr[1][5:0]);
    put(rtype(7'h20, 1, 4, F3_SRL_SRA, 14), 1, 14, $signed(xr[4]) >>> xr[1][5:0]);
    put(rtype(7'h00, 3, 1, F3_OR, 15), 1, 15, xr[1] | xr[3]);
    put(rtype(7'h00, 3, 2, F3_AND, 16), 1, 16, xr[2] & xr[3]);
    // shift amounts above 31 need the sixth bit
    put(itype(OPC_OP_IMM, 17, F3_SLL, 1, 40), 1, 17, xr[1] << 40);
    put(itype(OPC_OP_IMM, 18, F3_SRL_SRA, 4, 'h400 | 33), 1, 18, $signed(xr[4]) >>> 33);
    put(itype(OPC_OP_IMM, 19, F3_SRL_SRA, 2, 60), 1, 19, xr[2] >> 60);
    put(itype(OPC_OP_IMM, 20, F3_SLTU, 1, -1), 1, 20, {63'b0, xr[1] < sx(-1)});
    put(itype(OPC_OP_IMM, 21, F3_SLT, 2, -2), 1, 21, {63'b0, $signed(xr[2]) < $signed(sx(-2))});
    put(itype(OPC_OP_IMM, 22, F3_XOR, 2, -1), 1, 22, xr[2] ^ sx(-1));
    put(itype(OPC_OP_IMM, 23, F3_OR, 1, 'h70), 1, 23, xr[1] | sx('h70));
    put(itype(OPC_OP_IMM, 24, F3_AND, 2, 'hf0), 1, 24, xr[2] & sx('hf0));
    put(addi(0, 1, 7), 1, 0, xr[1] + sx(7));
    put(addi(10, 0, 'h3c), 1, 10, sx('h3c));
    put(halt_word(), 0, 0, '0);
  endtask

  task automatic test_alu();
    begin_program("alu");
    build_alu_program();
    run_program();
    check_commits(xr[10][7:0]);
    check_quiet();
    finish_test();
  endtask

  task automatic test_branch();
    begin_program("branch");
    put(addi(1, 0, 3), 1, 1, sx(3));
    put(addi(2, 0, 3), 1, 2, sx(3));
    // taken beq skips 0x0c and 0x10
    put(btype(F3_BEQ, 1, 2, 12), 0, 0, '0);
    prog_pc = 64'h14;
    put(btype(F3_BNE, 1, 2, 8), 0, 0, '0);
    put(addi(3, 0, -1), 1, 3, sx(-1));
    put(btype(F3_BLT, 3, 1, 8), 0, 0, '0);
    prog_pc = 64'h24;
    // -1 is the largest unsigned value
    put(btype(F3_BLTU, 3, 1, 8), 0, 0, '0);
    put(btype(F3_BGE, 1, 3, 8), 0, 0, '0);
    prog_pc = 64'h30;
    put(btype(F3_BGEU, 1, 3, 8), 0, 0, '0);
    put(jtype(4, 12), 1, 4, prog_pc + 64'd4);
    prog_pc = 64'h40;
    put(addi(6, 0, 'h51), 1, 6, sx('h51));
    // target 0x55 loses bit 0
    put(itype(OPC_JALR, 7, 3'b000, 6, 4), 1, 7, prog_pc + 64'd4);
    prog_pc = 64'h54;
    put(addi(10, 0, 'h5a), 1, 10, sx('h5a));
    put(halt_word(), 0, 0, '0);
    run_program();
    check_commits(xr[10][7:0]);
    check_quiet();
    finish_test();
  endtask

  task automatic test_halt();
    begin_program("halt");
    put(addi(10, 0, 'h1a5), 1, 10, sx('h1a5));
    put(addi(1, 10, 1), 1, 1, xr[10] + sx(1));
    put(halt_word(), 0, 0, '0);
    run_program();
    check_commits(xr[10][7:0]);
    check_quiet();
    finish_test();
  endtask

  task automatic test_bus_error();
    begin_program("bus_error");
    err_addr = 64'h8;
    put(addi(1, 0, 1), 1, 1, sx(1));
    put(addi(2, 0, 2), 1, 2, sx(2));
    put(addi(3, 0, 3), 0, 3, '0);
    put(addi(4, 0, 4), 1, 4, sx(4));
    // the fourth instruction is never reached
    void'(exp_pc.pop_back());
    void'(exp_inst.pop_back());
    void'(exp_wen.pop_back());
    void'(exp_rd.pop_back());
    void'(exp_val.pop_back());
    run_program();
    check_commits(TRAP_BUS_ERR);
    check_quiet();
    assert (fetch_count == 3) else begin
      errors++;
      $display("Mismatch: %s: fetch count expected 3, actual %0d", cur_test, fetch_count);
    end
    finish_test();
  endtask

  task automatic test_illegal();
    begin_program("illegal");
    put(addi(1, 0, 9), 1, 1, sx(9));
    // load opcode is outside the supported set
    put(itype(7'h03, 5, 3'b011, 0, 0), 0, 5, '0);
    run_program();
    check_commits(TRAP_ILLEGAL);
    check_quiet();
    finish_test();
  endtask

  task automatic test_backpressure();
    begin_program("backpressure");
    stall_req = 4;
    build_alu_program();
    run_program();
    check_commits(xr[10][7:0]);
    check_quiet();
    assert (stall_seen) else begin
      errors++;
      $display("ERROR: %s: the long ready stall was never applied", cur_test);
    end
    assert (c_pc.size() == fetch_count) else begin
      errors++;
      $display("Mismatch: %s: commits per fetch expected %0d, actual %0d", cur_test,
               fetch_count, c_pc.size());
    end
    finish_test();
  endtask

  initial begin
    clock          = 1'b0;
    reset          = 1'b1;
    if_ready_i     = 1'b0;
    if_data_read_i = '0;
    if_resp_i      = RESP_OKAY;
    test_alu();
    test_branch();
    test_halt();
    test_bus_error();
    test_illegal();
    test_backpressure();
    $display("tests run: %0d, passed: %0d, failed: %0d", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== files.f ====
hw/core_pkg.sv
hw/core_intf.sv
hw/fetch_unit.sv
hw/decoder.sv
hw/regfile.sv
hw/exec_unit.sv
hw/commit_unit.sv
hw/core_top.sv
test/tb_core.sv
